// ==== src/mcpu_params.svh ====
`ifndef MCPU_PARAMS_SVH
`define MCPU_PARAMS_SVH

// First fetch address after reset
`define MCPU_RESET_PC 32'h1c00_0000

// Datapath width
`define MCPU_XLEN 32

// Architectural register count
`define MCPU_NREGS 32

`endif

// ==== src/mcpu_isa_pkg.sv ====
`include "mcpu_params.svh"

package mcpu_isa_pkg;

    typedef logic [`MCPU_XLEN-1:0] word_t;
    typedef logic [$clog2(`MCPU_NREGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_UNCOND, BR_EQ, BR_NE, BR_JIRL
    } br_kind_t;

    // Major opcodes in inst[31:26]
    localparam logic [5:0] OP6_ALU   = 6'h00;
    localparam logic [5:0] OP6_LU12I = 6'h05;
    localparam logic [5:0] OP6_MEM   = 6'h0a;
    localparam logic [5:0] OP6_JIRL  = 6'h13;
    localparam logic [5:0] OP6_B     = 6'h14;
    localparam logic [5:0] OP6_BL    = 6'h15;
    localparam logic [5:0] OP6_BEQ   = 6'h16;
    localparam logic [5:0] OP6_BNE   = 6'h17;

endpackage

// ==== src/mcpu_ctrl_pkg.sv ====
package mcpu_ctrl_pkg;

    // One state per phase, each phase lasts one cycle
    typedef enum logic [2:0] {
        IF  = 3'd0,
        ID  = 3'd1,
        EXE = 3'd2,
        MEM = 3'd3,
        WB  = 3'd4
    } state_t;

    // Writeback value source
    typedef enum logic {
        WB_SRC_ALU = 1'b0,
        WB_SRC_MEM = 1'b1
    } wb_src_t;

endpackage

// ==== src/mcpu_control.sv ====
`include "mcpu_params.svh"

module mcpu_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  branch_taken,
    input  mcpu_isa_pkg::word_t   branch_target,
    input  mcpu_isa_pkg::word_t   inst_sram_rdata,
    input  logic                  is_branch_only,
    input  logic                  is_mem,
    input  logic                  is_load,
    output mcpu_ctrl_pkg::state_t state,
    output mcpu_isa_pkg::word_t   pc,
    output mcpu_isa_pkg::word_t   inst,
    output mcpu_isa_pkg::word_t   inst_sram_addr
);

    mcpu_ctrl_pkg::state_t next_state;
    mcpu_isa_pkg::word_t   pc_next;
    logic                  retire;

    always_comb begin
        case (state)
            mcpu_ctrl_pkg::IF:  next_state = mcpu_ctrl_pkg::ID;
            mcpu_ctrl_pkg::ID:  next_state = is_branch_only ? mcpu_ctrl_pkg::IF : mcpu_ctrl_pkg::EXE;
            mcpu_ctrl_pkg::EXE: next_state = is_mem ? mcpu_ctrl_pkg::MEM : mcpu_ctrl_pkg::WB;
            mcpu_ctrl_pkg::MEM: next_state = is_load ? mcpu_ctrl_pkg::WB : mcpu_ctrl_pkg::IF;
            default:            next_state = mcpu_ctrl_pkg::IF;
        endcase
    end

    // Last edge of the instruction, PC moves on here
    assign retire = (state == mcpu_ctrl_pkg::ID && is_branch_only) ||
                    (state == mcpu_ctrl_pkg::MEM && !is_load) ||
                    (state == mcpu_ctrl_pkg::WB);
    assign pc_next = branch_taken ? branch_target : pc + mcpu_isa_pkg::word_t'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mcpu_ctrl_pkg::IF;
            pc    <= `MCPU_RESET_PC;
        end else begin
            state <= next_state;
            if (retire) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == mcpu_ctrl_pkg::IF) begin
            inst <= inst_sram_rdata;
        end
    end

    assign inst_sram_addr = pc;

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {mcpu_ctrl_pkg::IF, mcpu_ctrl_pkg::ID, mcpu_ctrl_pkg::EXE,
                      mcpu_ctrl_pkg::MEM, mcpu_ctrl_pkg::WB});

    // Branch targets come from execute, so this covers its offset math too
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== src/mcpu_decode.sv ====
module mcpu_decode (
    input  mcpu_isa_pkg::word_t      inst,
    output mcpu_isa_pkg::alu_op_t    alu_op,
    output mcpu_isa_pkg::br_kind_t   br_kind,
    output logic                     src1_is_pc,
    output logic                     src2_is_imm,
    output logic                     reg_we,
    output logic                     mem_we,
    output logic                     is_load,
    output logic                     is_mem,
    output logic                     is_branch_only,
    output mcpu_ctrl_pkg::wb_src_t   wb_src,
    output mcpu_isa_pkg::reg_idx_t   raddr1,
    output mcpu_isa_pkg::reg_idx_t   raddr2,
    output mcpu_isa_pkg::reg_idx_t   dest,
    output mcpu_isa_pkg::word_t      imm,
    output mcpu_isa_pkg::word_t      br_offs
);

    logic [5:0]             op6;
    logic [3:0]             op4;
    logic [1:0]             op2;
    logic [4:0]             op5;
    mcpu_isa_pkg::reg_idx_t rd;
    mcpu_isa_pkg::reg_idx_t rj;
    mcpu_isa_pkg::reg_idx_t rk;
    logic [11:0]            i12;
    logic [19:0]            i20;
    logic [15:0]            i16;
    logic [25:0]            i26;
    logic                   imm_is_four;
    logic                   imm_is_ui20;
    logic                   offs_is_26;
    logic                   src2_is_rd;
    logic                   dst_is_r1;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];
    assign i16 = inst[25:10];
    assign i26 = {inst[9:0], inst[25:10]};

    always_comb begin
        // Anything not matched below falls through as a no-op
        alu_op         = mcpu_isa_pkg::ALU_ADD;
        br_kind        = mcpu_isa_pkg::BR_NONE;
        src1_is_pc     = 1'b0;
        src2_is_imm    = 1'b0;
        reg_we         = 1'b0;
        mem_we         = 1'b0;
        is_load        = 1'b0;
        is_mem         = 1'b0;
        is_branch_only = 1'b0;
        wb_src         = mcpu_ctrl_pkg::WB_SRC_ALU;
        imm_is_four    = 1'b0;
        imm_is_ui20    = 1'b0;
        offs_is_26     = 1'b0;
        src2_is_rd     = 1'b0;
        dst_is_r1      = 1'b0;
        case (op6)
            mcpu_isa_pkg::OP6_ALU: begin
                if (op4 == 4'h0 && op2 == 2'h1) begin
                    reg_we = 1'b1;
                    case (op5)
                        5'h00:   alu_op = mcpu_isa_pkg::ALU_ADD;
                        5'h02:   alu_op = mcpu_isa_pkg::ALU_SUB;
                        5'h04:   alu_op = mcpu_isa_pkg::ALU_SLT;
                        5'h05:   alu_op = mcpu_isa_pkg::ALU_SLTU;
                        5'h08:   alu_op = mcpu_isa_pkg::ALU_NOR;
                        5'h09:   alu_op = mcpu_isa_pkg::ALU_AND;
                        5'h0a:   alu_op = mcpu_isa_pkg::ALU_OR;
                        5'h0b:   alu_op = mcpu_isa_pkg::ALU_XOR;
                        default: reg_we = 1'b0;
                    endcase
                end else if (op4 == 4'h1 && op2 == 2'h0) begin
                    // Shift amount sits in the low bits of i12
                    reg_we      = 1'b1;
                    src2_is_imm = 1'b1;
                    case (op5)
                        5'h01:   alu_op = mcpu_isa_pkg::ALU_SLL;
                        5'h09:   alu_op = mcpu_isa_pkg::ALU_SRL;
                        5'h11:   alu_op = mcpu_isa_pkg::ALU_SRA;
                        default: reg_we = 1'b0;
                    endcase
                end else if (op4 == 4'ha) begin
                    reg_we      = 1'b1;
                    src2_is_imm = 1'b1;
                end
            end
            mcpu_isa_pkg::OP6_LU12I: begin
                if (!inst[25]) begin
                    alu_op      = mcpu_isa_pkg::ALU_LUI;
                    reg_we      = 1'b1;
                    src2_is_imm = 1'b1;
                    imm_is_ui20 = 1'b1;
                end
            end
            mcpu_isa_pkg::OP6_MEM: begin
                if (op4 == 4'h2) begin
                    is_mem      = 1'b1;
                    is_load     = 1'b1;
                    reg_we      = 1'b1;
                    src2_is_imm = 1'b1;
                    wb_src      = mcpu_ctrl_pkg::WB_SRC_MEM;
                end else if (op4 == 4'h6) begin
                    is_mem      = 1'b1;
                    mem_we      = 1'b1;
                    src2_is_imm = 1'b1;
                    src2_is_rd  = 1'b1;
                end
            end
            mcpu_isa_pkg::OP6_JIRL: begin
                br_kind     = mcpu_isa_pkg::BR_JIRL;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm_is_four = 1'b1;
                reg_we      = 1'b1;
            end
            mcpu_isa_pkg::OP6_B: begin
                br_kind        = mcpu_isa_pkg::BR_UNCOND;
                is_branch_only = 1'b1;
                offs_is_26     = 1'b1;
            end
            mcpu_isa_pkg::OP6_BL: begin
                br_kind     = mcpu_isa_pkg::BR_UNCOND;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm_is_four = 1'b1;
                reg_we      = 1'b1;
                offs_is_26  = 1'b1;
                dst_is_r1   = 1'b1;
            end
            mcpu_isa_pkg::OP6_BEQ: begin
                br_kind        = mcpu_isa_pkg::BR_EQ;
                is_branch_only = 1'b1;
                src2_is_rd     = 1'b1;
            end
            mcpu_isa_pkg::OP6_BNE: begin
                br_kind        = mcpu_isa_pkg::BR_NE;
                is_branch_only = 1'b1;
                src2_is_rd     = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm = imm_is_four ? mcpu_isa_pkg::word_t'(4) :
                 imm_is_ui20 ? {i20, 12'b0} :
                 {{20{i12[11]}}, i12};

    assign br_offs = offs_is_26 ? {{4{i26[25]}}, i26, 2'b00} : {{14{i16[15]}}, i16, 2'b00};

    assign raddr1 = rj;
    assign raddr2 = src2_is_rd ? rd : rk;
    // bl links through r1
    assign dest   = dst_is_r1 ? mcpu_isa_pkg::reg_idx_t'(1) : rd;

endmodule

// ==== src/mcpu_regfile.sv ====
`include "mcpu_params.svh"

module mcpu_regfile (
    input  logic                   clk,
    input  mcpu_isa_pkg::reg_idx_t raddr1,
    input  mcpu_isa_pkg::reg_idx_t raddr2,
    input  mcpu_isa_pkg::reg_idx_t waddr,
    output mcpu_isa_pkg::word_t    rdata1,
    output mcpu_isa_pkg::word_t    rdata2,
    input  logic                   we,
    input  mcpu_isa_pkg::word_t    wdata
);

    mcpu_isa_pkg::word_t regs [`MCPU_NREGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero whatever was written to it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr));

endmodule

// ==== src/mcpu_execute.sv ====
module mcpu_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  mcpu_ctrl_pkg::state_t  state,
    input  mcpu_isa_pkg::alu_op_t  alu_op,
    input  mcpu_isa_pkg::br_kind_t br_kind,
    input  logic                   src1_is_pc,
    input  logic                   src2_is_imm,
    input  logic                   mem_we,
    input  mcpu_isa_pkg::word_t    pc,
    input  mcpu_isa_pkg::word_t    rj_value,
    input  mcpu_isa_pkg::word_t    rkd_value,
    input  mcpu_isa_pkg::word_t    imm,
    input  mcpu_isa_pkg::word_t    br_offs,
    output mcpu_isa_pkg::word_t    alu_result,
    output logic                   branch_taken,
    output mcpu_isa_pkg::word_t    branch_target,
    output logic                   data_sram_we,
    output mcpu_isa_pkg::word_t    data_sram_addr,
    output mcpu_isa_pkg::word_t    data_sram_wdata
);

    mcpu_isa_pkg::word_t src1;
    mcpu_isa_pkg::word_t src2;
    mcpu_isa_pkg::word_t alu_out;
    mcpu_isa_pkg::word_t store_data;
    logic [4:0]          shamt;
    logic                rj_eq_rd;

    assign src1  = src1_is_pc ? pc : rj_value;
    assign src2  = src2_is_imm ? imm : rkd_value;
    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op)
            mcpu_isa_pkg::ALU_ADD:  alu_out = src1 + src2;
            mcpu_isa_pkg::ALU_SUB:  alu_out = src1 - src2;
            mcpu_isa_pkg::ALU_SLT:  alu_out = {31'b0, $signed(src1) < $signed(src2)};
            mcpu_isa_pkg::ALU_SLTU: alu_out = {31'b0, src1 < src2};
            mcpu_isa_pkg::ALU_AND:  alu_out = src1 & src2;
            mcpu_isa_pkg::ALU_NOR:  alu_out = ~(src1 | src2);
            mcpu_isa_pkg::ALU_OR:   alu_out = src1 | src2;
            mcpu_isa_pkg::ALU_XOR:  alu_out = src1 ^ src2;
            mcpu_isa_pkg::ALU_SLL:  alu_out = src1 << shamt;
            mcpu_isa_pkg::ALU_SRL:  alu_out = src1 >> shamt;
            mcpu_isa_pkg::ALU_SRA:  alu_out = $signed(src1) >>> shamt;
            mcpu_isa_pkg::ALU_LUI:  alu_out = src2;
            default:                alu_out = '0;
        endcase
    end

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (br_kind)
            mcpu_isa_pkg::BR_UNCOND: branch_taken = 1'b1;
            mcpu_isa_pkg::BR_JIRL:   branch_taken = 1'b1;
            mcpu_isa_pkg::BR_EQ:     branch_taken = rj_eq_rd;
            mcpu_isa_pkg::BR_NE:     branch_taken = !rj_eq_rd;
            default:                 branch_taken = 1'b0;
        endcase
    end

    // jirl is register relative and every other branch is PC relative
    assign branch_target = (br_kind == mcpu_isa_pkg::BR_JIRL) ? rj_value + br_offs : pc + br_offs;

    always_ff @(posedge clk) begin
        if (state == mcpu_ctrl_pkg::EXE) begin
            alu_result <= alu_out;
            store_data <= rkd_value;
        end
    end

    assign data_sram_we    = (state == mcpu_ctrl_pkg::MEM) && mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = store_data;

    // A store ends its instruction and the core fetches next
    a_store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |=> state == mcpu_ctrl_pkg::IF);

endmodule

// ==== src/mcpu_result.sv ====
module mcpu_result (
    input  logic                   clk,
    input  mcpu_ctrl_pkg::state_t  state,
    input  mcpu_ctrl_pkg::wb_src_t wb_src,
    input  logic                   reg_we,
    input  mcpu_isa_pkg::reg_idx_t dest,
    input  mcpu_isa_pkg::word_t    pc,
    input  mcpu_isa_pkg::word_t    alu_result,
    input  mcpu_isa_pkg::word_t    data_sram_rdata,
    output logic                   rf_we,
    output mcpu_isa_pkg::reg_idx_t rf_waddr,
    output mcpu_isa_pkg::word_t    rf_wdata,
    output mcpu_isa_pkg::word_t    debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output mcpu_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output mcpu_isa_pkg::word_t    debug_wb_rf_wdata
);

    mcpu_isa_pkg::word_t load_data;

    always_ff @(posedge clk) begin
        if (state == mcpu_ctrl_pkg::MEM) begin
            load_data <= data_sram_rdata;
        end
    end

    assign rf_we    = reg_we && (state == mcpu_ctrl_pkg::WB);
    assign rf_waddr = dest;
    assign rf_wdata = (wb_src == mcpu_ctrl_pkg::WB_SRC_MEM) ? load_data : alu_result;

    // PC has not moved yet during WB
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== src/mcpu_top.sv ====
module mcpu_top (
    input  logic                   clk,
    input  logic                   reset,
    output mcpu_isa_pkg::word_t    inst_sram_addr,
    input  mcpu_isa_pkg::word_t    inst_sram_rdata,
    output logic                   data_sram_we,
    output mcpu_isa_pkg::word_t    data_sram_addr,
    output mcpu_isa_pkg::word_t    data_sram_wdata,
    input  mcpu_isa_pkg::word_t    data_sram_rdata,
    output mcpu_isa_pkg::word_t    debug_wb_pc,
    output logic [3:0]             debug_wb_rf_we,
    output mcpu_isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output mcpu_isa_pkg::word_t    debug_wb_rf_wdata
);

    mcpu_ctrl_pkg::state_t  state;
    mcpu_ctrl_pkg::wb_src_t wb_src;
    mcpu_isa_pkg::alu_op_t  alu_op;
    mcpu_isa_pkg::br_kind_t br_kind;
    mcpu_isa_pkg::word_t    pc;
    mcpu_isa_pkg::word_t    inst;
    mcpu_isa_pkg::word_t    imm;
    mcpu_isa_pkg::word_t    br_offs;
    mcpu_isa_pkg::word_t    rj_value;
    mcpu_isa_pkg::word_t    rkd_value;
    mcpu_isa_pkg::word_t    alu_result;
    mcpu_isa_pkg::word_t    branch_target;
    mcpu_isa_pkg::word_t    rf_wdata;
    mcpu_isa_pkg::reg_idx_t raddr1;
    mcpu_isa_pkg::reg_idx_t raddr2;
    mcpu_isa_pkg::reg_idx_t dest;
    mcpu_isa_pkg::reg_idx_t rf_waddr;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic                   reg_we;
    logic                   mem_we;
    logic                   is_load;
    logic                   is_mem;
    logic                   is_branch_only;
    logic                   branch_taken;
    logic                   rf_we;

    mcpu_control i_control (
        .clk, .reset, .branch_taken, .branch_target, .inst_sram_rdata,
        .is_branch_only, .is_mem, .is_load, .state, .pc, .inst, .inst_sram_addr
    );

    mcpu_decode i_decode (
        .inst, .alu_op, .br_kind, .src1_is_pc, .src2_is_imm, .reg_we, .mem_we,
        .is_load, .is_mem, .is_branch_only, .wb_src, .raddr1, .raddr2, .dest,
        .imm, .br_offs
    );

    mcpu_regfile i_regfile (
        .clk, .raddr1, .raddr2, .waddr(rf_waddr), .rdata1(rj_value),
        .rdata2(rkd_value), .we(rf_we), .wdata(rf_wdata)
    );

    mcpu_execute i_execute (
        .clk, .reset, .state, .alu_op, .br_kind, .src1_is_pc, .src2_is_imm,
        .mem_we, .pc, .rj_value, .rkd_value, .imm, .br_offs, .alu_result,
        .branch_taken, .branch_target, .data_sram_we, .data_sram_addr,
        .data_sram_wdata
    );

    mcpu_result i_result (
        .clk, .state, .wb_src, .reg_we, .dest, .pc, .alu_result, .data_sram_rdata,
        .rf_we, .rf_waddr, .rf_wdata, .debug_wb_pc, .debug_wb_rf_we,
        .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Released just after the 16th rising edge
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== tb/tb_mcpu_top.sv ====
`include "mcpu_params.svh"

module tb_mcpu_top;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 12;
    localparam int MAX_ENTRIES  = 64;
    localparam int DMEM_WORDS   = 256;

    typedef enum {
        K_ADD, K_SUB, K_SLT, K_SLTU, K_NOR, K_AND, K_OR, K_XOR,
        K_SLLI, K_SRLI, K_SRAI, K_ADDI, K_LU12I, K_LD, K_ST,
        K_JIRL, K_B, K_BL, K_BEQ, K_BNE
    } kind_t;

    logic                   clk;
    logic                   reset;
    mcpu_isa_pkg::word_t    inst_sram_addr;
    mcpu_isa_pkg::word_t    inst_sram_rdata;
    logic                   data_sram_we;
    mcpu_isa_pkg::word_t    data_sram_addr;
    mcpu_isa_pkg::word_t    data_sram_wdata;
    mcpu_isa_pkg::word_t    data_sram_rdata;
    mcpu_isa_pkg::word_t    debug_wb_pc;
    logic [3:0]             debug_wb_rf_we;
    mcpu_isa_pkg::reg_idx_t debug_wb_rf_wnum;
    mcpu_isa_pkg::word_t    debug_wb_rf_wdata;

    // Program table, one entry per instruction word in memory order
    string                  t_name [MAX_ENTRIES];
    kind_t                  t_kind [MAX_ENTRIES];
    mcpu_isa_pkg::reg_idx_t t_rd [MAX_ENTRIES];
    mcpu_isa_pkg::reg_idx_t t_rj [MAX_ENTRIES];
    mcpu_isa_pkg::reg_idx_t t_rk [MAX_ENTRIES];
    int                     t_imm [MAX_ENTRIES];
    mcpu_isa_pkg::word_t    t_word [MAX_ENTRIES];
    logic                   t_done [MAX_ENTRIES];
    logic                   t_writes [MAX_ENTRIES];
    mcpu_isa_pkg::reg_idx_t t_widx [MAX_ENTRIES];
    mcpu_isa_pkg::word_t    t_wdata [MAX_ENTRIES];
    mcpu_isa_pkg::word_t    t_wpc [MAX_ENTRIES];
    int                     n_entries = 0;

    mcpu_isa_pkg::word_t    dmem [DMEM_WORDS];
    mcpu_isa_pkg::word_t    model_mem [DMEM_WORDS];
    mcpu_isa_pkg::word_t    lfsr_state;
    int                     writes_expected = 0;
    int                     writes_seen = 0;
    logic                   table_ready = 1'b0;

    tb_clock i_clock (
        .clk,
        .reset
    );

    mcpu_top i_dut (
        .clk, .reset, .inst_sram_addr, .inst_sram_rdata, .data_sram_we,
        .data_sram_addr, .data_sram_wdata, .data_sram_rdata, .debug_wb_pc,
        .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input string what,
                              input mcpu_isa_pkg::word_t exp, input mcpu_isa_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s %s: expected %h, actual %h", name, what, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input mcpu_isa_pkg::reg_idx_t exp,
                             input mcpu_isa_pkg::reg_idx_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s wnum: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic mcpu_isa_pkg::word_t lfsr_word();
        mcpu_isa_pkg::word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic int mem_index(input mcpu_isa_pkg::word_t addr);
        return int'(addr[9:2]);
    endfunction

    function automatic mcpu_isa_pkg::word_t imem_read(input mcpu_isa_pkg::word_t addr);
        mcpu_isa_pkg::word_t offset;
        mcpu_isa_pkg::word_t w;
        offset = addr - `MCPU_RESET_PC;
        if (offset < 4 * n_entries) begin
            w = t_word[offset[31:2]];
        end else begin
            w = '0;
        end
        return w;
    endfunction

    // LoongArch encodings, branch offsets given in words
    function automatic mcpu_isa_pkg::word_t encode(input kind_t kind,
                                                   input mcpu_isa_pkg::reg_idx_t rd,
                                                   input mcpu_isa_pkg::reg_idx_t rj,
                                                   input mcpu_isa_pkg::reg_idx_t rk,
                                                   input int imm);
        mcpu_isa_pkg::word_t regs3;
        mcpu_isa_pkg::word_t w;
        regs3 = {17'b0, rk, rj, rd};
        case (kind)
            K_ADD:   w = 32'h0010_0000 | regs3;
            K_SUB:   w = 32'h0011_0000 | regs3;
            K_SLT:   w = 32'h0012_0000 | regs3;
            K_SLTU:  w = 32'h0012_8000 | regs3;
            K_NOR:   w = 32'h0014_0000 | regs3;
            K_AND:   w = 32'h0014_8000 | regs3;
            K_OR:    w = 32'h0015_0000 | regs3;
            K_XOR:   w = 32'h0015_8000 | regs3;
            K_SLLI:  w = 32'h0040_8000 | {17'b0, imm[4:0], rj, rd};
            K_SRLI:  w = 32'h0044_8000 | {17'b0, imm[4:0], rj, rd};
            K_SRAI:  w = 32'h0048_8000 | {17'b0, imm[4:0], rj, rd};
            K_ADDI:  w = 32'h0280_0000 | {10'b0, imm[11:0], rj, rd};
            K_LU12I: w = 32'h1400_0000 | {7'b0, imm[19:0], rd};
            K_LD:    w = 32'h2880_0000 | {10'b0, imm[11:0], rj, rd};
            K_ST:    w = 32'h2980_0000 | {10'b0, imm[11:0], rj, rd};
            K_JIRL:  w = 32'h4c00_0000 | {6'b0, imm[15:0], rj, rd};
            K_B:     w = 32'h5000_0000 | {6'b0, imm[15:0], imm[25:16]};
            K_BL:    w = 32'h5400_0000 | {6'b0, imm[15:0], imm[25:16]};
            K_BEQ:   w = 32'h5800_0000 | {6'b0, imm[15:0], rj, rd};
            K_BNE:   w = 32'h5c00_0000 | {6'b0, imm[15:0], rj, rd};
            default: w = '0;
        endcase
        return w;
    endfunction

    task automatic add_entry(input string name, input kind_t kind, input int rd, input int rj,
                             input int rk, input int imm);
        t_name[n_entries] = name;
        t_kind[n_entries] = kind;
        t_rd[n_entries]   = rd[4:0];
        t_rj[n_entries]   = rj[4:0];
        t_rk[n_entries]   = rk[4:0];
        t_imm[n_entries]  = imm;
        t_word[n_entries] = encode(kind, rd[4:0], rj[4:0], rk[4:0], imm);
        t_done[n_entries] = 1'b0;
        n_entries++;
    endtask

    task automatic build_program();
        add_entry("lu12i_w", K_LU12I, 4, 0, 0, 'h80001);
        add_entry("addi_w_pos", K_ADDI, 4, 4, 0, 'h234);
        add_entry("addi_w_neg", K_ADDI, 5, 0, 0, -5);
        add_entry("addi_w_r6", K_ADDI, 6, 0, 0, 'h7f3);
        add_entry("add_w", K_ADD, 7, 4, 6, 0);
        add_entry("sub_w", K_SUB, 8, 6, 4, 0);
        add_entry("slt", K_SLT, 9, 5, 6, 0);
        add_entry("sltu", K_SLTU, 10, 5, 6, 0);
        add_entry("and", K_AND, 11, 4, 5, 0);
        add_entry("or", K_OR, 12, 4, 6, 0);
        add_entry("nor", K_NOR, 13, 4, 6, 0);
        add_entry("xor", K_XOR, 14, 4, 5, 0);
        add_entry("add_w_to_r0", K_ADD, 0, 4, 6, 0);
        add_entry("read_r0", K_ADD, 15, 0, 6, 0);
        add_entry("slli_w", K_SLLI, 16, 4, 0, 4);
        add_entry("srli_w", K_SRLI, 17, 4, 0, 31);
        add_entry("srai_w_neg", K_SRAI, 18, 4, 0, 12);
        add_entry("srai_w_pos", K_SRAI, 19, 6, 0, 3);
        add_entry("addi_w_base", K_ADDI, 20, 0, 0, 'h40);
        add_entry("st_w", K_ST, 7, 20, 0, 8);
        add_entry("ld_w_stored", K_LD, 21, 20, 0, 8);
        add_entry("ld_w_lfsr", K_LD, 22, 20, 0, 'h100);
        add_entry("beq_taken", K_BEQ, 9, 9, 0, 2);
        add_entry("skipped_beq", K_ADDI, 24, 0, 0, 1);
        add_entry("after_beq", K_ADDI, 24, 0, 0, 3);
        add_entry("beq_untaken", K_BEQ, 10, 9, 0, 2);
        add_entry("after_beq_nt", K_ADDI, 25, 0, 0, 4);
        add_entry("bne_taken", K_BNE, 10, 9, 0, 2);
        add_entry("skipped_bne", K_ADDI, 25, 0, 0, 5);
        add_entry("after_bne", K_ADDI, 25, 0, 0, 6);
        add_entry("bne_untaken", K_BNE, 15, 6, 0, 2);
        add_entry("after_bne_nt", K_ADDI, 26, 0, 0, 7);
        add_entry("b", K_B, 0, 0, 0, 2);
        add_entry("skipped_b", K_ADDI, 26, 0, 0, 8);
        add_entry("bl", K_BL, 0, 0, 0, 2);
        add_entry("skipped_bl", K_ADDI, 27, 0, 0, 9);
        add_entry("jirl", K_JIRL, 28, 1, 0, 3);
        add_entry("skipped_jirl", K_ADDI, 29, 0, 0, 10);
        add_entry("after_jirl", K_ADDI, 29, 0, 0, 11);
        // Branch to itself parks the core
        add_entry("park", K_B, 0, 0, 0, 0);
    endtask

    // Walks the program by the ISA rules and fills in the expected writes
    task automatic run_model();
        mcpu_isa_pkg::word_t    regs [`MCPU_NREGS];
        mcpu_isa_pkg::word_t    pc;
        mcpu_isa_pkg::word_t    next_pc;
        mcpu_isa_pkg::word_t    a;
        mcpu_isa_pkg::word_t    b;
        mcpu_isa_pkg::word_t    d;
        mcpu_isa_pkg::word_t    res;
        mcpu_isa_pkg::word_t    offs;
        mcpu_isa_pkg::reg_idx_t widx;
        logic [4:0]             sh;
        logic                   wr;
        int                     i;
        foreach (regs[r]) regs[r] = '0;
        pc = `MCPU_RESET_PC;
        i = 0;
        while (i < n_entries && !t_done[i]) begin
            a = regs[t_rj[i]];
            b = regs[t_rk[i]];
            d = regs[t_rd[i]];
            sh = t_imm[i][4:0];
            offs = t_imm[i] << 2;
            res = '0;
            wr = 1'b1;
            widx = t_rd[i];
            next_pc = pc + 4;
            case (t_kind[i])
                K_ADD:   res = a + b;
                K_SUB:   res = a - b;
                K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
                K_NOR:   res = ~(a | b);
                K_AND:   res = a & b;
                K_OR:    res = a | b;
                K_XOR:   res = a ^ b;
                K_SLLI:  res = a << sh;
                K_SRLI:  res = a >> sh;
                K_SRAI:  res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                K_ADDI:  res = a + t_imm[i];
                K_LU12I: res = t_imm[i] << 12;
                K_LD:    res = model_mem[mem_index(a + t_imm[i])];
                K_ST: begin
                    model_mem[mem_index(a + t_imm[i])] = d;
                    wr = 1'b0;
                end
                K_JIRL: begin
                    res = pc + 4;
                    next_pc = a + offs;
                end
                K_BL: begin
                    res = pc + 4;
                    widx = 5'd1;
                    next_pc = pc + offs;
                end
                K_B: begin
                    wr = 1'b0;
                    next_pc = pc + offs;
                end
                K_BEQ: begin
                    wr = 1'b0;
                    next_pc = (a == d) ? pc + offs : pc + 4;
                end
                K_BNE: begin
                    wr = 1'b0;
                    next_pc = (a != d) ? pc + offs : pc + 4;
                end
                default: wr = 1'b0;
            endcase
            t_done[i] = 1'b1;
            t_writes[i] = wr;
            t_widx[i] = widx;
            t_wdata[i] = res;
            t_wpc[i] = pc;
            if (wr) begin
                writes_expected++;
                if (widx != 0) regs[widx] = res;
            end
            pc = next_pc;
            i = int'((pc - `MCPU_RESET_PC) >> 2);
        end
    endtask

    // Combinational SRAMs, refreshed just after each rising edge
    always @(posedge clk) begin
        #1;
        inst_sram_rdata = imem_read(inst_sram_addr);
        data_sram_rdata = dmem[mem_index(data_sram_addr)];
    end

    always @(negedge clk) begin
        if (data_sram_we) begin
            dmem[mem_index(data_sram_addr)] = data_sram_wdata;
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            if (debug_wb_rf_we !== 4'h0) stop_on_error("trace write reported while reset is held");
        end else if (debug_wb_rf_we != 4'h0) begin
            writes_seen++;
        end
    end

    initial begin
        wait (table_ready);
        #((RESET_CYCLES + 6 * n_entries + DRAIN_CYCLES) * CLK_PERIOD);
        stop_on_error("watchdog expired before all expected trace writes were seen");
    end

    initial begin
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        lfsr_state = 32'h3af7;
        for (int k = 0; k < DMEM_WORDS; k++) begin
            dmem[k] = lfsr_word();
            model_mem[k] = dmem[k];
        end
        build_program();
        run_model();
        table_ready = 1'b1;
        @(negedge reset);
        for (int i = 0; i < n_entries; i++) begin
            if (t_done[i] && t_writes[i]) begin
                while (debug_wb_rf_we == 4'h0) @(negedge clk);
                if (debug_wb_rf_we != 4'hf) begin
                    stop_on_error("trace write enable has only some of its four bits set");
                end
                check_word(t_name[i], "pc", t_wpc[i], debug_wb_pc);
                check_reg(t_name[i], t_widx[i], debug_wb_rf_wnum);
                check_word(t_name[i], "wdata", t_wdata[i], debug_wb_rf_wdata);
                @(negedge clk);
            end
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (writes_seen == writes_expected) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("saw %0d trace writes where the program makes %0d",
                                    writes_seen, writes_expected));
        end
    end

endmodule

// ==== mcpu_top.f ====
+incdir+src
src/mcpu_isa_pkg.sv
src/mcpu_ctrl_pkg.sv
src/mcpu_control.sv
src/mcpu_decode.sv
src/mcpu_regfile.sv
src/mcpu_execute.sv
src/mcpu_result.sv
src/mcpu_top.sv
tb/tb_clock.sv
tb/tb_mcpu_top.sv

// ==== Bender.yml ====
package:
  name: mcpu

sources:
  - include_dirs:
      - src
    files:
      - src/mcpu_isa_pkg.sv
      - src/mcpu_ctrl_pkg.sv
      - src/mcpu_control.sv
      - src/mcpu_decode.sv
      - src/mcpu_regfile.sv
      - src/mcpu_execute.sv
      - src/mcpu_result.sv
      - src/mcpu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clock.sv
      - tb/tb_mcpu_top.sv
